// ==== verilog/ahbSwitch_config.svh ====
// AHB switch configuration
`ifndef AHBSWITCH_CONFIG_SVH
`define AHBSWITCH_CONFIG_SVH

// Bus widths
`define AHB_ADDR_WIDTH 32
`define AHB_DATA_WIDTH 32

// Port counts on both sides of the switch
`define SWITCH_MASTERS 2
`define SWITCH_SLAVES 2
// Enough bits to name one master port
`define MASTER_INDEX_WIDTH 1

// Fixed address map
// Selected when (addr & mask) == (base & mask)
`define SLAVE0_BASE 32'h0000_0000
`define SLAVE0_MASK 32'hF000_0000
`define SLAVE1_BASE 32'h1000_0000
`define SLAVE1_MASK 32'hF000_0000

`endif

// ==== verilog/ahbSwitchPkg.sv ====
// AHB switch shared types
`include "ahbSwitch_config.svh"

package ahbSwitchPkg;

  //////////////////////////////////////////////////
  // Bus encodings
  //////////////////////////////////////////////////

  // AHB HTRANS encoding
  typedef enum logic [1:0]
  {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  // Address phase signals from one master
  typedef struct packed
  {
    logic                       hSel;
    logic [`AHB_ADDR_WIDTH-1:0] hAddr;
    logic                       hWrite;
    logic [2:0]                 hSize;
    htrans_e                    hTrans;
  } ahbRequest_t;

  // Response signals from one slave
  typedef struct packed
  {
    logic [`AHB_DATA_WIDTH-1:0] hRData;
    logic                       hReadyOut;
    logic                       hResp;
  } ahbResponse_t;

  //////////////////////////////////////////////////
  // Control state encodings
  //////////////////////////////////////////////////

  // Data phase owner of one slave
  typedef enum logic [1:0]
  {
    GRANT_NONE = 2'd0,
    GRANT_M0   = 2'd1,
    GRANT_M1   = 2'd2
  } grantState_e;

  // Two cycle error response sequence
  typedef enum logic [1:0]
  {
    ERR_IDLE   = 2'd0,
    ERR_FIRST  = 2'd1,
    ERR_SECOND = 2'd2
  } errorState_e;

endpackage

// ==== verilog/addressDecoder.sv ====
// AHB switch address decoder
`timescale 1ns/10ps
`include "ahbSwitch_config.svh"

module addressDecoder
(
  input  logic [`AHB_ADDR_WIDTH-1:0] hAddr,
  input  logic                       hSel,
  output logic [`SWITCH_SLAVES-1:0]  slaveSelect,
  output logic                       noSlave
);

  // Map taken from the config header
  localparam logic [`AHB_ADDR_WIDTH-1:0] SlaveBase [`SWITCH_SLAVES] =
    '{`SLAVE0_BASE, `SLAVE1_BASE};
  localparam logic [`AHB_ADDR_WIDTH-1:0] SlaveMask [`SWITCH_SLAVES] =
    '{`SLAVE0_MASK, `SLAVE1_MASK};

  // Raw hits before priority
  logic [`SWITCH_SLAVES-1:0] match;

  always_comb
  begin
    for (int s = 0; s < `SWITCH_SLAVES; s++)
      match[s] = (hAddr & SlaveMask[s]) == (SlaveBase[s] & SlaveMask[s]);
  end

  // First hit wins so overlapping windows go to the lower slave
  always_comb
  begin
    logic found;
    found       = 1'b0;
    slaveSelect = '0;
    for (int s = 0; s < `SWITCH_SLAVES; s++)
    begin
      if (hSel && match[s] && !found)
      begin
        slaveSelect[s] = 1'b1;
        found          = 1'b1;
      end
    end
  end

  // Unmapped access gets the error response upstream
  assign noSlave = hSel && !(|match);

endmodule

// ==== verilog/masterPort.sv ====
// AHB switch master port
`timescale 1ns/10ps
`include "ahbSwitch_config.svh"

module masterPort
(
  input  logic                               HCLK,
  input  logic                               reset,
  // AHB master side
  input  ahbSwitchPkg::ahbRequest_t          masterRequest,
  input  logic                               masterReady,
  output ahbSwitchPkg::ahbResponse_t         masterResponse,
  // Decoder result for portRequest
  input  logic [`SWITCH_SLAVES-1:0]          slaveSelect,
  input  logic                               noSlave,
  // Arbiter handshake
  input  logic                               granted,
  input  logic [$clog2(`SWITCH_SLAVES)-1:0]  dataSlave,
  input  logic                               dataValid,
  input  ahbSwitchPkg::ahbResponse_t         slaveResponses [`SWITCH_SLAVES],
  output ahbSwitchPkg::ahbRequest_t          portRequest
);

  //////////////////////////////////////////////////
  // Address phase buffer
  //////////////////////////////////////////////////

  logic                      bufferValid;
  ahbSwitchPkg::ahbRequest_t bufferRequest;
  logic                      liveActive;
  logic                      liveAccept;
  ahbSwitchPkg::errorState_e errorState;

  // NONSEQ or SEQ with hSel
  assign liveActive = masterRequest.hSel &&
                      (masterRequest.hTrans == ahbSwitchPkg::NONSEQ ||
                       masterRequest.hTrans == ahbSwitchPkg::SEQ);

  // Master samples its own address phase here
  assign liveAccept = !bufferValid && masterReady && liveActive;

  // Buffered phase takes over until the arbiter grants it
  always_comb
  begin
    if (bufferValid)
    begin
      portRequest = bufferRequest;
    end
    else
    begin
      portRequest      = masterRequest;
      // Not sampled yet while the master waits
      portRequest.hSel = masterRequest.hSel && masterReady;
    end
  end

  always_ff @(posedge HCLK)
  begin
    if (reset)
      bufferValid <= 1'b0;
    else if (liveAccept && (|slaveSelect) && !granted)
      bufferValid <= 1'b1;
    else if (bufferValid && granted)
      bufferValid <= 1'b0;
  end

  // Stored address phase while it waits for a grant
  always_ff @(posedge HCLK)
  begin
    if (liveAccept && !granted)
      bufferRequest <= masterRequest;
  end

  //////////////////////////////////////////////////
  // Error response for unmapped addresses
  //////////////////////////////////////////////////

  always_ff @(posedge HCLK)
  begin
    if (reset)
      errorState <= ahbSwitchPkg::ERR_IDLE;
    else
    begin
      case (errorState)
        ahbSwitchPkg::ERR_IDLE:
          if (liveAccept && noSlave)
            errorState <= ahbSwitchPkg::ERR_FIRST;
        ahbSwitchPkg::ERR_FIRST:
          errorState <= ahbSwitchPkg::ERR_SECOND;
        // Ready is high here so a new unmapped access may follow at once
        ahbSwitchPkg::ERR_SECOND:
          errorState <= (liveAccept && noSlave) ? ahbSwitchPkg::ERR_FIRST
                                                : ahbSwitchPkg::ERR_IDLE;
        default:
          errorState <= ahbSwitchPkg::ERR_IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Response back to the master
  //////////////////////////////////////////////////

  always_comb
  begin
    masterResponse.hRData = slaveResponses[dataSlave].hRData;
    if (errorState == ahbSwitchPkg::ERR_FIRST)
    begin
      masterResponse.hReadyOut = 1'b0;
      masterResponse.hResp     = 1'b1;
    end
    else if (errorState == ahbSwitchPkg::ERR_SECOND)
    begin
      masterResponse.hReadyOut = 1'b1;
      masterResponse.hResp     = 1'b1;
    end
    // Stall while the buffered phase waits for its slave
    else if (bufferValid)
    begin
      masterResponse.hReadyOut = 1'b0;
      masterResponse.hResp     = 1'b0;
    end
    else if (dataValid)
    begin
      masterResponse.hReadyOut = slaveResponses[dataSlave].hReadyOut;
      masterResponse.hResp     = slaveResponses[dataSlave].hResp;
    end
    else
    begin
      masterResponse.hReadyOut = 1'b1;
      masterResponse.hResp     = 1'b0;
    end
  end

  // Error sequence never overlaps a stalled or running slave data phase
  errorAlone: assert property (@(posedge HCLK) disable iff (reset)
    (errorState != ahbSwitchPkg::ERR_IDLE) |-> (!bufferValid && !dataValid));

endmodule

// ==== verilog/switchArbiter.sv ====
// AHB switch arbiter
`timescale 1ns/10ps
`include "ahbSwitch_config.svh"

module switchArbiter
(
  input  logic                               HCLK,
  input  logic                               reset,
  input  ahbSwitchPkg::ahbRequest_t          portRequests   [`SWITCH_MASTERS],
  input  logic [`SWITCH_SLAVES-1:0]          slaveSelects   [`SWITCH_MASTERS],
  input  ahbSwitchPkg::ahbResponse_t         slaveResponses [`SWITCH_SLAVES],
  // Per master
  output logic [`SWITCH_MASTERS-1:0]         granted,
  output logic [$clog2(`SWITCH_SLAVES)-1:0]  dataSlave      [`SWITCH_MASTERS],
  output logic [`SWITCH_MASTERS-1:0]         dataValid,
  // Per slave
  output logic [`MASTER_INDEX_WIDTH-1:0]     addrOwner      [`SWITCH_SLAVES],
  output logic [`SWITCH_SLAVES-1:0]          addrValid
);

  localparam int SlaveIndexWidth = $clog2(`SWITCH_SLAVES);

  logic [`SWITCH_MASTERS-1:0]                     reqActive;
  logic [`SWITCH_SLAVES-1:0]                      accepted;
  logic [`SWITCH_MASTERS-1:0][`SWITCH_SLAVES-1:0] grantMatrix;
  ahbSwitchPkg::grantState_e                      grantState [`SWITCH_SLAVES];

  // Only NONSEQ and SEQ compete for a slave
  always_comb
  begin
    for (int m = 0; m < `SWITCH_MASTERS; m++)
      reqActive[m] = portRequests[m].hSel &&
                     (portRequests[m].hTrans == ahbSwitchPkg::NONSEQ ||
                      portRequests[m].hTrans == ahbSwitchPkg::SEQ);
  end

  //////////////////////////////////////////////////
  // Address phase ownership per slave
  //////////////////////////////////////////////////

  for (genvar s = 0; s < `SWITCH_SLAVES; s++)
  begin : gSlave
    logic [`SWITCH_MASTERS-1:0] requesters;

    always_comb
    begin
      for (int m = 0; m < `SWITCH_MASTERS; m++)
        requesters[m] = reqActive[m] && slaveSelects[m][s];
    end

    // Fixed priority with master 0 highest
    always_comb
    begin
      addrOwner[s] = '0;
      for (int m = `SWITCH_MASTERS - 1; m >= 0; m--)
        if (requesters[m])
          addrOwner[s] = `MASTER_INDEX_WIDTH'(m);
    end

    // Free slave or current data phase finishing
    assign addrValid[s] = (|requesters) &&
                          (grantState[s] == ahbSwitchPkg::GRANT_NONE ||
                           slaveResponses[s].hReadyOut);
    assign accepted[s]  = addrValid[s] && slaveResponses[s].hReadyOut;

    // Owner holds the slave until its data phase ends
    always_ff @(posedge HCLK)
    begin
      if (reset)
        grantState[s] <= ahbSwitchPkg::GRANT_NONE;
      else if (accepted[s])
        grantState[s] <= ahbSwitchPkg::grantState_e'({1'b0, addrOwner[s]} + 2'd1);
      else if (slaveResponses[s].hReadyOut)
        grantState[s] <= ahbSwitchPkg::GRANT_NONE;
    end
  end

  //////////////////////////////////////////////////
  // Per master grant and data phase slave
  //////////////////////////////////////////////////

  always_comb
  begin
    for (int m = 0; m < `SWITCH_MASTERS; m++)
    begin
      dataValid[m] = 1'b0;
      dataSlave[m] = '0;
      for (int s = 0; s < `SWITCH_SLAVES; s++)
      begin
        grantMatrix[m][s] = accepted[s] && (addrOwner[s] == `MASTER_INDEX_WIDTH'(m));
        if (grantState[s] == ahbSwitchPkg::grantState_e'(m + 1))
        begin
          dataValid[m] = 1'b1;
          dataSlave[m] = SlaveIndexWidth'(s);
        end
      end
      granted[m] = |grantMatrix[m];
    end
  end

  for (genvar m = 0; m < `SWITCH_MASTERS; m++)
  begin : gGrantCheck
    singleGrant: assert property (@(posedge HCLK) disable iff (reset)
      $onehot0(grantMatrix[m]));
  end

endmodule

// ==== verilog/slavePort.sv ====
// AHB switch slave port
`timescale 1ns/10ps
`include "ahbSwitch_config.svh"

module slavePort
(
  input  logic                               HCLK,
  input  logic                               reset,
  // From every master port
  input  ahbSwitchPkg::ahbRequest_t          portRequests [`SWITCH_MASTERS],
  input  logic [`AHB_DATA_WIDTH-1:0]         masterWData  [`SWITCH_MASTERS],
  // From the arbiter
  input  logic [`MASTER_INDEX_WIDTH-1:0]     addrOwner,
  input  logic                               addrValid,
  // AHB slave side
  output ahbSwitchPkg::ahbRequest_t          slaveRequest,
  output logic [`AHB_DATA_WIDTH-1:0]         slaveWData,
  output logic                               slaveReady,
  input  ahbSwitchPkg::ahbResponse_t         slaveResponse
);

  //////////////////////////////////////////////////
  // Address phase steering
  //////////////////////////////////////////////////

  // Master whose data phase is on this slave
  logic [`MASTER_INDEX_WIDTH-1:0] dataOwner;
  logic                           addrAccept;

  always_comb
  begin
    slaveRequest = portRequests[addrOwner];
    // Slave sees an idle bus when nobody holds the address phase
    if (!addrValid)
    begin
      slaveRequest.hSel   = 1'b0;
      slaveRequest.hTrans = ahbSwitchPkg::IDLE;
    end
  end

  // Single owner so the slave's own ready is its HREADY
  assign slaveReady = slaveResponse.hReadyOut;

  // Slave samples the address on this edge
  assign addrAccept = addrValid && slaveResponse.hReadyOut;

  //////////////////////////////////////////////////
  // Data phase steering
  //////////////////////////////////////////////////

  always_ff @(posedge HCLK)
  begin
    if (reset)
      dataOwner <= '0;
    else if (addrAccept)
      dataOwner <= addrOwner;
  end

  // Write data follows one cycle behind its address
  assign slaveWData = masterWData[dataOwner];

endmodule

// ==== verilog/ahbSwitch.sv ====
// AHB multi-layer switch
`timescale 1ns/10ps
`include "ahbSwitch_config.svh"

module ahbSwitch
(
  input  logic                        HCLK,
  input  logic                        reset,
  // Master side
  input  ahbSwitchPkg::ahbRequest_t   mstRequest  [`SWITCH_MASTERS],
  input  logic [`AHB_DATA_WIDTH-1:0]  mstWData    [`SWITCH_MASTERS],
  input  logic                        mstReady    [`SWITCH_MASTERS],
  output ahbSwitchPkg::ahbResponse_t  mstResponse [`SWITCH_MASTERS],
  // Slave side
  output ahbSwitchPkg::ahbRequest_t   slvRequest  [`SWITCH_SLAVES],
  output logic [`AHB_DATA_WIDTH-1:0]  slvWData    [`SWITCH_SLAVES],
  output logic                        slvReady    [`SWITCH_SLAVES],
  input  ahbSwitchPkg::ahbResponse_t  slvResponse [`SWITCH_SLAVES]
);

  // Live or buffered request per master
  ahbSwitchPkg::ahbRequest_t              portRequest [`SWITCH_MASTERS];
  logic [`SWITCH_SLAVES-1:0]              slaveSelect [`SWITCH_MASTERS];
  logic                                   noSlave     [`SWITCH_MASTERS];
  // Arbiter results
  logic [`SWITCH_MASTERS-1:0]             granted;
  logic [$clog2(`SWITCH_SLAVES)-1:0]      dataSlave   [`SWITCH_MASTERS];
  logic [`SWITCH_MASTERS-1:0]             dataValid;
  logic [`MASTER_INDEX_WIDTH-1:0]         addrOwner   [`SWITCH_SLAVES];
  logic [`SWITCH_SLAVES-1:0]              addrValid;

  //////////////////////////////////////////////////
  // Master paths
  //////////////////////////////////////////////////

  for (genvar m = 0; m < `SWITCH_MASTERS; m++)
  begin : gMasterPath
    // Decodes what the port forwards
    addressDecoder decoder
    (
      .hAddr       (portRequest[m].hAddr),
      .hSel        (portRequest[m].hSel),
      .slaveSelect (slaveSelect[m]),
      .noSlave     (noSlave[m])
    );

    masterPort port
    (
      .HCLK           (HCLK),
      .reset          (reset),
      .masterRequest  (mstRequest[m]),
      .masterReady    (mstReady[m]),
      .masterResponse (mstResponse[m]),
      .slaveSelect    (slaveSelect[m]),
      .noSlave        (noSlave[m]),
      .granted        (granted[m]),
      .dataSlave      (dataSlave[m]),
      .dataValid      (dataValid[m]),
      .slaveResponses (slvResponse),
      .portRequest    (portRequest[m])
    );
  end

  //////////////////////////////////////////////////
  // Arbitration
  //////////////////////////////////////////////////

  switchArbiter arbiter
  (
    .HCLK           (HCLK),
    .reset          (reset),
    .portRequests   (portRequest),
    .slaveSelects   (slaveSelect),
    .slaveResponses (slvResponse),
    .granted        (granted),
    .dataSlave      (dataSlave),
    .dataValid      (dataValid),
    .addrOwner      (addrOwner),
    .addrValid      (addrValid)
  );

  //////////////////////////////////////////////////
  // Slave paths
  //////////////////////////////////////////////////

  for (genvar s = 0; s < `SWITCH_SLAVES; s++)
  begin : gSlavePath
    slavePort port
    (
      .HCLK          (HCLK),
      .reset         (reset),
      .portRequests  (portRequest),
      .masterWData   (mstWData),
      .addrOwner     (addrOwner[s]),
      .addrValid     (addrValid[s]),
      .slaveRequest  (slvRequest[s]),
      .slaveWData    (slvWData[s]),
      .slaveReady    (slvReady[s]),
      .slaveResponse (slvResponse[s])
    );
  end

endmodule

// ==== verification/tbAhbSwitch.sv ====
// AHB switch testbench
`timescale 1ns/10ps
`include "ahbSwitch_config.svh"

module tbAhbSwitch;

  localparam int ClockPeriod       = 100;
  localparam int ResetCycles       = 2;
  localparam int DirectedTransfers = 10;
  localparam int RandomTransfers   = 60;
  // Both masters run the random phase
  localparam int TotalTransfers    = DirectedTransfers + 2 * RandomTransfers;
  localparam int TimeoutCycles     = TotalTransfers * 20 + ResetCycles;

  logic                        HCLK;
  logic                        reset;
  ahbSwitchPkg::ahbRequest_t   mstRequest  [`SWITCH_MASTERS];
  logic [`AHB_DATA_WIDTH-1:0]  mstWData    [`SWITCH_MASTERS];
  logic                        mstReady    [`SWITCH_MASTERS];
  ahbSwitchPkg::ahbResponse_t  mstResponse [`SWITCH_MASTERS];
  ahbSwitchPkg::ahbRequest_t   slvRequest  [`SWITCH_SLAVES];
  logic [`AHB_DATA_WIDTH-1:0]  slvWData    [`SWITCH_SLAVES];
  logic                        slvReady    [`SWITCH_SLAVES];
  ahbSwitchPkg::ahbResponse_t  slvResponse [`SWITCH_SLAVES];

  // Scoreboard memory holding the last value written per address
  logic [`AHB_DATA_WIDTH-1:0]  model [logic [`AHB_ADDR_WIDTH-1:0]];

  ahbSwitch uut
  (
    .HCLK        (HCLK),
    .reset       (reset),
    .mstRequest  (mstRequest),
    .mstWData    (mstWData),
    .mstReady    (mstReady),
    .mstResponse (mstResponse),
    .slvRequest  (slvRequest),
    .slvWData    (slvWData),
    .slvReady    (slvReady),
    .slvResponse (slvResponse)
  );

  // Master HREADY is the switch's own ready back to that master
  for (genvar m = 0; m < `SWITCH_MASTERS; m++)
  begin : gMasterReady
    assign mstReady[m] = mstResponse[m].hReadyOut;
  end

  initial
  begin
    HCLK = 1'b0;
    forever #(ClockPeriod / 2) HCLK = ~HCLK;
  end

  //////////////////////////////////////////////////
  // Reference model helpers
  //////////////////////////////////////////////////

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected)
    begin
      $display("ERROR at %0t: %s = %0h, expected %0h", $time, name, actual, expected);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  // Address map with -1 for unmapped
  function automatic int decodeSlave(input logic [`AHB_ADDR_WIDTH-1:0] addr);
    if ((addr & `SLAVE0_MASK) == (`SLAVE0_BASE & `SLAVE0_MASK))
      return 0;
    if ((addr & `SLAVE1_MASK) == (`SLAVE1_BASE & `SLAVE1_MASK))
      return 1;
    return -1;
  endfunction

  // Content of a word never written
  function automatic logic [`AHB_DATA_WIDTH-1:0] fillWord(input logic [`AHB_ADDR_WIDTH-1:0] addr);
    return addr ^ 32'h5A5A_C3C3;
  endfunction

  function automatic ahbSwitchPkg::ahbRequest_t idleRequest();
    ahbSwitchPkg::ahbRequest_t request;
    request        = '0;
    request.hTrans = ahbSwitchPkg::IDLE;
    return request;
  endfunction

  // Mostly mapped words from a small window so reads hit earlier writes
  function automatic logic [`AHB_ADDR_WIDTH-1:0] randomAddress();
    logic [`AHB_ADDR_WIDTH-1:0] offset;
    int                         pick;
    offset = ($urandom % 16) << 2;
    pick   = $urandom % 8;
    if (pick == 0)
      return 32'h2000_0000 + ($urandom % 14) * 32'h1000_0000 + offset;
    return ((pick < 4) ? `SLAVE0_BASE : `SLAVE1_BASE) + offset;
  endfunction

  //////////////////////////////////////////////////
  // Master side
  //////////////////////////////////////////////////

  // One NONSEQ single transfer checked against the model
  task automatic runTransfer(input int m, input logic [`AHB_ADDR_WIDTH-1:0] addr,
                             input logic write, input logic [`AHB_DATA_WIDTH-1:0] wdata);
    ahbSwitchPkg::ahbRequest_t  request;
    logic [`AHB_DATA_WIDTH-1:0] expected;
    int                         dataCycle;
    bit                         mapped;
    mapped         = decodeSlave(addr) >= 0;
    request        = idleRequest();
    request.hSel   = 1'b1;
    request.hAddr  = addr;
    request.hWrite = write;
    request.hSize  = 3'b010;
    request.hTrans = ahbSwitchPkg::NONSEQ;
    @(posedge HCLK);
    mstRequest[m] <= request;
    // Address phase ends on the first edge with ready high
    do
    begin
      @(posedge HCLK);
    end
    while (!mstResponse[m].hReadyOut);
    mstRequest[m] <= idleRequest();
    mstWData[m]   <= wdata;
    dataCycle = 0;
    do
    begin
      @(posedge HCLK);
      if (!mapped)
      begin
        // Two cycle error with ready low then high
        checkValue($sformatf("mstResponse[%0d].hReadyOut", m),
                   mstResponse[m].hReadyOut, dataCycle == 1);
        checkValue($sformatf("mstResponse[%0d].hResp", m), mstResponse[m].hResp, 1);
      end
      else
        checkValue($sformatf("mstResponse[%0d].hResp", m), mstResponse[m].hResp, 0);
      dataCycle++;
    end
    while (!mstResponse[m].hReadyOut);
    if (mapped && write)
      model[addr] = wdata;
    else if (mapped)
    begin
      expected = model.exists(addr) ? model[addr] : fillWord(addr);
      checkValue($sformatf("mstResponse[%0d].hRData", m), mstResponse[m].hRData, expected);
    end
  endtask

  task automatic randomTraffic(input int m);
    int gap;
    for (int i = 0; i < RandomTransfers; i++)
    begin
      runTransfer(m, randomAddress(), $urandom % 2, $urandom);
      gap = $urandom % 4;
      repeat (gap) @(posedge HCLK);
    end
  endtask

  //////////////////////////////////////////////////
  // Slave memory models
  //////////////////////////////////////////////////

  for (genvar s = 0; s < `SWITCH_SLAVES; s++)
  begin : gSlaveModel
    logic [`AHB_DATA_WIDTH-1:0] mem [logic [`AHB_ADDR_WIDTH-1:0]];
    logic [`AHB_ADDR_WIDTH-1:0] phaseAddr;
    logic                       phaseWrite;
    logic                       busy;
    int                         waitLeft;
    ahbSwitchPkg::ahbResponse_t nextResponse;

    initial
    begin
      busy           = 1'b0;
      waitLeft       = 0;
      phaseAddr      = '0;
      phaseWrite     = 1'b0;
      slvResponse[s] = '{hRData: '0, hReadyOut: 1'b1, hResp: 1'b0};
      forever
      begin
        @(posedge HCLK);
        nextResponse = '{hRData: '0, hReadyOut: 1'b1, hResp: 1'b0};
        if (reset)
          busy = 1'b0;
        else
        begin
          // Slave HREADY follows this slave's own ready
          checkValue($sformatf("slvReady[%0d]", s), slvReady[s], slvResponse[s].hReadyOut);
          // Data phase ends here so write data is valid now
          if (busy && slvResponse[s].hReadyOut)
          begin
            if (phaseWrite)
              mem[phaseAddr] = slvWData[s];
            busy = 1'b0;
          end
          else if (busy)
            waitLeft--;
          if (slvReady[s] && slvRequest[s].hSel &&
              (slvRequest[s].hTrans == ahbSwitchPkg::NONSEQ ||
               slvRequest[s].hTrans == ahbSwitchPkg::SEQ))
          begin
            // Misrouted or unmapped address never reaches this slave
            checkValue($sformatf("slave %0d decode of %0h", s, slvRequest[s].hAddr),
                       decodeSlave(slvRequest[s].hAddr), s);
            checkValue($sformatf("slvRequest[%0d].hSize", s), slvRequest[s].hSize, 3'b010);
            phaseAddr  = slvRequest[s].hAddr;
            phaseWrite = slvRequest[s].hWrite;
            busy       = 1'b1;
            waitLeft   = $urandom % 4;
          end
          nextResponse.hReadyOut = !busy || waitLeft == 0;
          if (busy && !phaseWrite && waitLeft == 0)
            nextResponse.hRData = mem.exists(phaseAddr) ? mem[phaseAddr] : fillWord(phaseAddr);
        end
        slvResponse[s] <= nextResponse;
      end
    end
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial
  begin
    #(TimeoutCycles * ClockPeriod);
    $display("Watchdog expired before all transfers had completed");
    $display("Test failed");
    $fatal(1);
  end

  initial
  begin
    logic [`AHB_DATA_WIDTH-1:0] data;
    void'($urandom(52150));
    reset = 1'b1;
    for (int m = 0; m < `SWITCH_MASTERS; m++)
    begin
      mstRequest[m] = idleRequest();
      mstWData[m]   = '0;
    end
    repeat (ResetCycles) @(posedge HCLK);
    reset <= 1'b0;
    // Idle state straight out of reset
    @(posedge HCLK);
    for (int m = 0; m < `SWITCH_MASTERS; m++)
    begin
      checkValue($sformatf("mstResponse[%0d].hReadyOut", m), mstResponse[m].hReadyOut, 1);
      checkValue($sformatf("mstResponse[%0d].hResp", m), mstResponse[m].hResp, 0);
    end
    for (int s = 0; s < `SWITCH_SLAVES; s++)
      checkValue($sformatf("slvRequest[%0d].hSel", s), slvRequest[s].hSel, 0);
    // Write then read back on the same master
    data = $urandom;
    runTransfer(0, `SLAVE0_BASE + 32'h10, 1'b1, data);
    runTransfer(0, `SLAVE0_BASE + 32'h10, 1'b0, '0);
    data = $urandom;
    runTransfer(1, `SLAVE1_BASE + 32'h20, 1'b1, data);
    runTransfer(1, `SLAVE1_BASE + 32'h20, 1'b0, '0);
    // Cross reads between the two masters
    data = $urandom;
    runTransfer(0, `SLAVE1_BASE + 32'h40, 1'b1, data);
    runTransfer(1, `SLAVE1_BASE + 32'h40, 1'b0, '0);
    data = $urandom;
    runTransfer(1, `SLAVE0_BASE + 32'h44, 1'b1, data);
    runTransfer(0, `SLAVE0_BASE + 32'h44, 1'b0, '0);
    // Unmapped accesses
    runTransfer(0, 32'h3000_0000, 1'b1, $urandom);
    runTransfer(1, 32'hF000_0008, 1'b0, '0);
    fork
      randomTraffic(0);
      randomTraffic(1);
    join
    $display("Test completed successfully");
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+verilog
verilog/ahbSwitchPkg.sv
verilog/addressDecoder.sv
verilog/masterPort.sv
verilog/switchArbiter.sv
verilog/slavePort.sv
verilog/ahbSwitch.sv
verification/tbAhbSwitch.sv

// ==== Bender.yml ====
package:
  name: ahb_switch

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/ahbSwitchPkg.sv
      - verilog/addressDecoder.sv
      - verilog/masterPort.sv
      - verilog/switchArbiter.sv
      - verilog/slavePort.sv
      - verilog/ahbSwitch.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verification/tbAhbSwitch.sv
